/* src/dsp_pkg.sv */
// router widths, source and sink codes, reset defaults, bus structs and enums
`default_nettype none

package dsp_pkg;

   localparam int SAMPLE_W    = 14;             // adc/dac sample width
   localparam int N_SLOTS     = 8;              // external processing slots
   localparam int SEL_W       = 4;              // source select width
   localparam int N_SOURCES   = 14;             // codes 0..13 carry a sample
   localparam int N_SINKS     = 12;             // slots, two scopes, two pwm
   localparam int N_DIRECT    = 10;             // slots plus both generators
   localparam int SUM_W       = SAMPLE_W + SEL_W;
   localparam int SUM_LATENCY = 5;              // direct input to dac_o
   localparam int N_LEAVES    = 16;             // tree padded to a power of two
   localparam int SAMPLE_MAX  = 2**(SAMPLE_W-1) - 1;
   localparam int SAMPLE_MIN  = -(2**(SAMPLE_W-1));

   localparam logic [SEL_W-1:0] SRC_INVALID = 4'd14;   // the one dead code

   // sink indices after the slots
   localparam int SINK_SCOPE1 = 8;
   localparam int SINK_SCOPE2 = 9;
   localparam int SINK_PWM0   = 10;
   localparam int SINK_PWM1   = 11;

   typedef logic signed [SAMPLE_W-1:0] sample_t;

   typedef struct packed {
      sample_t ch1;
      sample_t ch2;
   } sample_pair_t;

   typedef sample_t [N_SLOTS-1:0]   slot_bus_t;
   typedef sample_t [N_SOURCES-1:0] src_bus_t;     // routing matrix inputs
   typedef sample_t [N_DIRECT-1:0]  direct_bus_t;  // adder tree contributors

   typedef enum logic [SEL_W-1:0] {
      SRC_SLOT0 = 4'd0,
      SRC_SLOT1 = 4'd1,
      SRC_SLOT2 = 4'd2,
      SRC_SLOT3 = 4'd3,
      SRC_SLOT4 = 4'd4,
      SRC_SLOT5 = 4'd5,
      SRC_SLOT6 = 4'd6,
      SRC_SLOT7 = 4'd7,
      SRC_ASG1  = 4'd8,
      SRC_ASG2  = 4'd9,
      SRC_ADC1  = 4'd10,
      SRC_ADC2  = 4'd11,
      SRC_DAC1  = 4'd12,     // dac feedback
      SRC_DAC2  = 4'd13,
      SRC_NONE  = 4'd15      // routes zero
   } src_sel_e;

   typedef enum logic [1:0] {
      OUT_OFF  = 2'b00,
      OUT_1    = 2'b01,      // bit 0 adds to dac1
      OUT_2    = 2'b10,      // bit 1 adds to dac2
      OUT_BOTH = 2'b11
   } out_sel_e;

   typedef enum logic [2:0] {
      REG_INPUT_SEL  = 3'd0,
      REG_OUTPUT_SEL = 3'd1,
      REG_STATUS     = 3'd2,
      REG_SIGNAL     = 3'd3  // codes 4..7 are errors
   } cfg_reg_e;

   typedef struct packed {
      logic        req;
      logic        we;
      logic [3:0]  slot;     // sink, contributor or source index
      cfg_reg_e    reg_sel;
      logic [31:0] wdata;
   } cfg_req_t;

   typedef struct packed {
      logic        ack;
      logic        err;      // valid with ack
      logic [31:0] rdata;
   } cfg_rsp_t;

   typedef src_sel_e [N_SINKS-1:0]  sink_sel_t;
   typedef out_sel_e [N_DIRECT-1:0] direct_sel_t;
   typedef logic [1:0]              sat_flags_t;   // bit 0 dac1, bit 1 dac2

   // leftmost entry is pwm1, rightmost is slot 0
   localparam sink_sel_t RST_SINK_SEL = '{
      SRC_NONE, SRC_NONE,                          // pwm1, pwm0
      SRC_ADC2, SRC_ADC1,                          // scope2, scope1
      SRC_ADC1, SRC_ADC1, SRC_ADC1, SRC_ADC1,      // slots 7..4
      SRC_ADC1, SRC_ADC1, SRC_ADC1, SRC_ADC1       // slots 3..0
   };

   localparam direct_sel_t RST_DIRECT_SEL = '{default: OUT_OFF};

endpackage

`default_nettype wire

/* src/dsp_cfg_regs.sv */
// routing and output-select registers with four-phase req/ack responder and readback
`timescale 1ns/1ps
`default_nettype none

module dsp_cfg_regs
   import dsp_pkg::*;
(
   input  logic        clk_i,
   input  logic        rstn_i,
   input  cfg_req_t    cfg_req_i,
   output cfg_rsp_t    cfg_o,
   input  src_bus_t    sources_i,
   input  sat_flags_t  sat_i,
   output sink_sel_t   sink_sel_o,
   output direct_sel_t direct_sel_o
);

   typedef enum logic {
      ST_IDLE,               // waiting for req
      ST_ACK                 // ack held until req drops
   } rsp_state_e;

   rsp_state_e  state_q;
   sink_sel_t   sink_sel_q;
   direct_sel_t direct_sel_q;
   logic        err_q;
   logic [31:0] rdata_q;     // captured once per access

   logic        accept;      // new request seen this cycle
   logic        err_c;
   logic [31:0] rdata_c;
   logic        wr_sink;
   logic        wr_direct;

   assign accept = (state_q == ST_IDLE) && cfg_req_i.req;

   // decode slot and reg, flag the illegal combinations
   always_comb begin
      err_c     = 1'b0;
      rdata_c   = '0;        // errored reads return zero
      wr_sink   = 1'b0;
      wr_direct = 1'b0;
      case (cfg_req_i.reg_sel)
         REG_INPUT_SEL: begin
            if (int'(cfg_req_i.slot) >= N_SINKS) begin
               err_c = 1'b1;                       // past pwm1
            end else if (cfg_req_i.we && cfg_req_i.wdata[SEL_W-1:0] == SRC_INVALID) begin
               err_c = 1'b1;                       // code 14 has no source
            end else begin
               wr_sink = cfg_req_i.we;
               rdata_c = 32'(sink_sel_q[cfg_req_i.slot]);
            end
         end
         REG_OUTPUT_SEL: begin
            if (int'(cfg_req_i.slot) >= N_DIRECT) begin
               err_c = 1'b1;                       // scopes and pwm have no direct out
            end else begin
               wr_direct = cfg_req_i.we;
               rdata_c   = 32'(direct_sel_q[cfg_req_i.slot]);
            end
         end
         REG_STATUS: begin
            rdata_c = 32'(sat_i);                  // read only, slot ignored
         end
         REG_SIGNAL: begin
            if (int'(cfg_req_i.slot) >= N_SOURCES) begin
               err_c = 1'b1;
            end else begin
               rdata_c = {{(32-SAMPLE_W){1'b0}}, sources_i[cfg_req_i.slot]};
            end
         end
         default: begin
            err_c = 1'b1;                          // unknown reg code
         end
      endcase
   end

   // responder fsm and register writes
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         state_q      <= ST_IDLE;
         err_q        <= 1'b0;
         sink_sel_q   <= RST_SINK_SEL;
         direct_sel_q <= RST_DIRECT_SEL;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (accept) begin
                  state_q <= ST_ACK;
                  err_q   <= err_c;
                  if (wr_sink) begin
                     sink_sel_q[cfg_req_i.slot] <= src_sel_e'(cfg_req_i.wdata[SEL_W-1:0]);
                  end
                  if (wr_direct) begin
                     direct_sel_q[cfg_req_i.slot] <= out_sel_e'(cfg_req_i.wdata[1:0]);
                  end
               end
            end
            ST_ACK: begin
               if (!cfg_req_i.req) begin
                  state_q <= ST_IDLE;              // ack drops one cycle after req
                  err_q   <= 1'b0;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         rdata_q <= rdata_c;
      end
   end

   assign cfg_o        = '{ack: (state_q == ST_ACK), err: err_q, rdata: rdata_q};
   assign sink_sel_o   = sink_sel_q;
   assign direct_sel_o = direct_sel_q;

   // ack only answers a request seen on the previous edge
   ack_follows_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
      $rose(cfg_o.ack) |-> $past(cfg_req_i.req));

   err_only_with_ack: assert property (@(posedge clk_i) disable iff (!rstn_i)
      cfg_o.err |-> cfg_o.ack);

   // the mux treats code 14 as zero, it must never be stored
   for (genvar g = 0; g < N_SINKS; g++) begin : g_sel_chk
      sel_in_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
         sink_sel_q[g] != SRC_INVALID);
   end

endmodule

`default_nettype wire

/* src/dsp_input_mux.sv */
// combinational source selection for slot, scope and pwm sinks
`timescale 1ns/1ps
`default_nettype none

module dsp_input_mux
   import dsp_pkg::*;
(
   input  src_bus_t     sources_i,
   input  sink_sel_t    sink_sel_i,
   output slot_bus_t    slot_input_o,
   output sample_pair_t scope_o,
   output sample_pair_t pwm_o
);

   sample_t [N_SINKS-1:0] sink_val;    // one routed sample per sink

   // anything past the dac feedback codes routes zero
   function automatic sample_t pick(input src_bus_t src, input src_sel_e sel);
      if (int'(sel) >= N_SOURCES) begin
         return '0;                    // SRC_NONE, also code 14
      end else begin
         return src[sel];
      end
   endfunction

   always_comb begin
      for (int k = 0; k < N_SINKS; k++) begin
         sink_val[k] = pick(sources_i, sink_sel_i[k]);
      end
   end

   assign slot_input_o = sink_val[N_SLOTS-1:0];   // sinks 0..7 feed the slots

   assign scope_o.ch1 = sink_val[SINK_SCOPE1];
   assign scope_o.ch2 = sink_val[SINK_SCOPE2];
   assign pwm_o.ch1   = sink_val[SINK_PWM0];      // reset select is SRC_NONE
   assign pwm_o.ch2   = sink_val[SINK_PWM1];

endmodule

`default_nettype wire

/* src/dsp_sum_tree.sv */
// pipelined two-channel adder tree over direct outputs with saturation and overflow flags
`timescale 1ns/1ps
`default_nettype none

module dsp_sum_tree
   import dsp_pkg::*;
(
   input  logic         clk_i,
   input  logic         rstn_i,
   input  direct_bus_t  direct_i,
   input  direct_sel_t  direct_sel_i,
   output sample_pair_t dac_o,
   output sat_flags_t   sat_o
);

   typedef logic signed [SUM_W-1:0] acc_t;   // 4 guard bits cover 16 leaves

   acc_t       leaf   [2][N_LEAVES];         // masked, sign-extended contributors
   acc_t       lvl1_q [2][N_LEAVES/2];       // stage 1 pair sums
   acc_t       lvl2_q [2][N_LEAVES/4];
   acc_t       lvl3_q [2][N_LEAVES/8];
   acc_t       lvl4_q [2];                   // stage 4 full channel sum
   sample_t    dac_q  [2];                   // stage 5 clamped output
   sat_flags_t sat_q;
   logic [1:0] ovf;                          // lvl4 sum outside sample range
   logic [1:0] en_any;                       // some contributor enabled

   function automatic sample_t clamp(input acc_t s);
      if (s > SAMPLE_MAX) begin
         return sample_t'(SAMPLE_MAX);
      end else if (s < SAMPLE_MIN) begin
         return sample_t'(SAMPLE_MIN);
      end else begin
         return sample_t'(s);                // fits without the guard bits
      end
   endfunction

   // channel c takes contributor i when bit c of its select is set
   always_comb begin
      for (int c = 0; c < 2; c++) begin
         en_any[c] = 1'b0;
         for (int i = 0; i < N_LEAVES; i++) begin
            leaf[c][i] = '0;                 // padding leaves stay zero
         end
         for (int i = 0; i < N_DIRECT; i++) begin
            if (direct_sel_i[i][c]) begin
               leaf[c][i] = acc_t'(direct_i[i]);   // sign extends
               en_any[c]  = 1'b1;
            end
         end
      end
   end

   always_comb begin
      for (int c = 0; c < 2; c++) begin
         ovf[c] = (lvl4_q[c] > SAMPLE_MAX) || (lvl4_q[c] < SAMPLE_MIN);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         lvl1_q <= '{default: '0};
         lvl2_q <= '{default: '0};
         lvl3_q <= '{default: '0};
         lvl4_q <= '{default: '0};
         dac_q  <= '{default: '0};           // dac_o starts at zero
         sat_q  <= '0;
      end else begin
         for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < N_LEAVES/2; i++) begin
               lvl1_q[c][i] <= leaf[c][2*i] + leaf[c][2*i+1];
            end
            for (int i = 0; i < N_LEAVES/4; i++) begin
               lvl2_q[c][i] <= lvl1_q[c][2*i] + lvl1_q[c][2*i+1];
            end
            for (int i = 0; i < N_LEAVES/8; i++) begin
               lvl3_q[c][i] <= lvl2_q[c][2*i] + lvl2_q[c][2*i+1];
            end
            lvl4_q[c] <= lvl3_q[c][0] + lvl3_q[c][1];
            dac_q[c]  <= clamp(lvl4_q[c]);   // saturate into the output register
            sat_q[c]  <= ovf[c];             // flag tracks the clamp
         end
      end
   end

   assign dac_o.ch1 = dac_q[0];
   assign dac_o.ch2 = dac_q[1];
   assign sat_o     = sat_q;

   for (genvar c = 0; c < 2; c++) begin : g_chk
      // flag set exactly when the clamp altered the stage 4 sum
      flag_matches_sum: assert property (@(posedge clk_i) disable iff (!rstn_i)
         sat_q[c] == (acc_t'(dac_q[c]) != $past(lvl4_q[c])));

      // nothing enabled at the tree input means silence at the far end
      idle_channel_zero: assert property (@(posedge clk_i) disable iff (!rstn_i)
         !$past(en_any[c], SUM_LATENCY) |-> dac_q[c] == '0);
   end

endmodule

`default_nettype wire

/* src/dsp_router.sv */
// top level joining configuration registers, routing matrix and dac adder tree
`timescale 1ns/1ps
`default_nettype none

module dsp_router
   import dsp_pkg::*;
(
   input  logic         clk_i,
   input  logic         rstn_i,
   input  sample_pair_t adc_i,
   input  sample_pair_t asg_i,
   input  slot_bus_t    slot_signal_i,   // routed slot outputs
   input  slot_bus_t    slot_direct_i,   // slot contributions to the dacs
   output slot_bus_t    slot_input_o,
   output sample_pair_t scope_o,
   output sample_pair_t pwm_o,
   output sample_pair_t dac_o,
   input  cfg_req_t     cfg_req_i,
   output cfg_rsp_t     cfg_o
);

   src_bus_t    sources;
   direct_bus_t direct;
   sink_sel_t   sink_sel;
   direct_sel_t direct_sel;
   sat_flags_t  sat;

   // source codes 13 down to 0, dac fed back from the tree register
   assign sources = {dac_o.ch2, dac_o.ch1,   // 13, 12
                     adc_i.ch2, adc_i.ch1,   // 11, 10
                     asg_i.ch2, asg_i.ch1,   // 9, 8
                     slot_signal_i};         // 7..0

   assign direct = {asg_i.ch2, asg_i.ch1, slot_direct_i};   // generators on top

   dsp_cfg_regs u_cfg_regs (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .cfg_req_i    (cfg_req_i),
      .cfg_o        (cfg_o),
      .sources_i    (sources),
      .sat_i        (sat),
      .sink_sel_o   (sink_sel),
      .direct_sel_o (direct_sel)
   );

   dsp_input_mux u_input_mux (
      .sources_i    (sources),
      .sink_sel_i   (sink_sel),
      .slot_input_o (slot_input_o),
      .scope_o      (scope_o),
      .pwm_o        (pwm_o)
   );

   dsp_sum_tree u_sum_tree (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .direct_i     (direct),
      .direct_sel_i (direct_sel),
      .dac_o        (dac_o),
      .sat_o        (sat)
   );

endmodule

`default_nettype wire

/* dv/dsp_router_model.svh */
// lfsr source, reference model of routing and summing, compare tasks, four-phase bus task
`ifndef DSP_ROUTER_MODEL_SVH
`define DSP_ROUTER_MODEL_SVH

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);   // galois, taps 32 30 26 25
endfunction

function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);          // one step per bit taken
      v    = {v[30:0], lfsr[0]};
   end
   return v;
endfunction

function automatic sample_t rand_sample(input int shift);
   sample_t s;
   s = sample_t'(rand_bits(SAMPLE_W));
   return s >>> shift;                 // shift shrinks the amplitude
endfunction

// source numbering: 0..7 slots, 8/9 asg, 10/11 adc, 12/13 dac
function automatic sample_t model_source(input int code);
   case (code)
      8:  return asg.ch1;
      9:  return asg.ch2;
      10: return adc.ch1;
      11: return adc.ch2;
      12: return dac_m.ch1;            // feedback of the held dac
      13: return dac_m.ch2;
      default: begin
         if (code < N_SLOTS) begin
            return slot_sig[code];
         end
         return '0;                    // none routes zero
      end
   endcase
endfunction

function automatic sample_t direct_val(input int i);
   if (i < N_SLOTS) begin
      return slot_dir[i];
   end
   return (i == N_SLOTS) ? asg.ch1 : asg.ch2;   // generators after the slots
endfunction

function automatic int chan_sum(input int ch);
   int         acc;
   logic [1:0] en;
   acc = 0;
   for (int i = 0; i < N_DIRECT; i++) begin
      en = dsel_m[i];
      if (en[ch]) begin
         acc += int'(direct_val(i));   // exact, no width limit
      end
   end
   return acc;
endfunction

function automatic sample_t saturate(input int s);
   if (s > SAT_HI) begin
      return sample_t'(SAT_HI);
   end else if (s < SAT_LO) begin
      return sample_t'(SAT_LO);
   end
   return sample_t'(s);
endfunction

function automatic sample_pair_t model_dac();
   sample_pair_t p;
   p.ch1 = saturate(chan_sum(0));
   p.ch2 = saturate(chan_sum(1));
   return p;
endfunction

function automatic sat_flags_t model_flags();
   sat_flags_t f;
   for (int c = 0; c < 2; c++) begin
      f[c] = (chan_sum(c) > SAT_HI) || (chan_sum(c) < SAT_LO);   // clamped channel
   end
   return f;
endfunction

task automatic cmp_sample(input string name, input sample_t exp, input sample_t act);
   checks++;
   if (act !== exp) begin
      $display("ERROR %s: expected %0d actual %0d", name, exp, act);
      errors++;
   end
endtask

task automatic cmp_pair(input string name, input sample_pair_t exp, input sample_pair_t act);
   checks++;
   if (act !== exp) begin
      $display("ERROR %s: expected (%0d,%0d) actual (%0d,%0d)", name,
               exp.ch1, exp.ch2, act.ch1, act.ch2);
      errors++;
   end
endtask

task automatic cmp_word(input string name, input logic [31:0] exp, input logic [31:0] act);
   checks++;
   if (act !== exp) begin
      $display("ERROR %s: expected 0x%08h actual 0x%08h", name, exp, act);
      errors++;
   end
endtask

task automatic cmp_flags(input string name, input sat_flags_t exp, input sat_flags_t act);
   checks++;
   if (act !== exp) begin
      $display("ERROR %s: expected %b actual %b", name, exp, act);
      errors++;
   end
endtask

// one four-phase access, read data and err captured while ack is high
task automatic cfg_access(input logic we, input cfg_reg_e r, input logic [3:0] slot,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
   int wait_n;
   cfg_req = '{req: 1'b1, we: we, slot: slot, reg_sel: r, wdata: wdata};
   rdata   = '0;
   err     = 1'b0;
   wait_n  = 0;
   do begin
      tick(1);
      wait_n++;
   end while (!cfg_rsp.ack && wait_n < 4);
   if (!cfg_rsp.ack) begin
      $display("config access to slot %0d got no ack within 4 cycles", slot);
      errors++;
   end else begin
      rdata = cfg_rsp.rdata;
      err   = cfg_rsp.err;
   end
   cfg_req.req = 1'b0;
   tick(1);                            // ack must be gone one cycle later
   if (cfg_rsp.ack) begin
      $display("config ack still high one cycle after req dropped");
      errors++;
   end
endtask

`endif

/* dv/tb_dsp_router.sv */
// dsp_router testbench with clock, reset, routing, summing, saturation, error and readback tests
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_router
   import dsp_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int DRIVE_DLY    = 2;     // inputs change this long after the edge
   localparam int RESET_CYCLES = 16;
   localparam int MAX_CYCLES   = 4000;  // test budgets plus margin
   localparam int N_ROUTE      = 200;
   localparam int N_STREAM     = 100;
   localparam int SAT_HI       = (2**(SAMPLE_W-1)) - 1;
   localparam int SAT_LO       = -(2**(SAMPLE_W-1));

   logic         clk;
   logic         rstn;
   sample_pair_t adc, asg, scope, pwm, dac;
   slot_bus_t    slot_sig, slot_dir, slot_in;
   cfg_req_t     cfg_req;
   cfg_rsp_t     cfg_rsp;

   logic [31:0]  lfsr = 32'hb778;
   sink_sel_t    ssel_m;               // model copy of the input selects
   direct_sel_t  dsel_m;               // model copy of the output selects
   sample_pair_t dac_m;                // settled dac the model expects
   int           errors = 0;
   int           checks = 0;
   int           cycle_cnt = 0;

   dsp_router DUT (
      .clk_i         (clk),
      .rstn_i        (rstn),
      .adc_i         (adc),
      .asg_i         (asg),
      .slot_signal_i (slot_sig),
      .slot_direct_i (slot_dir),
      .slot_input_o  (slot_in),
      .scope_o       (scope),
      .pwm_o         (pwm),
      .dac_o         (dac),
      .cfg_req_i     (cfg_req),
      .cfg_o         (cfg_rsp)
   );

   task automatic tick(input int n);
      repeat (n) @(posedge clk);
      #DRIVE_DLY;
   endtask

   `include "dsp_router_model.svh"

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   initial begin
      wait (cycle_cnt >= MAX_CYCLES);
      $display("timeout after %0d cycles, tests did not finish", cycle_cnt);
      $display("** FAIL **");
      $finish;
   end

   task automatic set_direct(input int i, input sample_t v);
      if (i < N_SLOTS) begin
         slot_dir[i] = v;
      end else if (i == N_SLOTS) begin
         asg.ch1 = v;
      end else begin
         asg.ch2 = v;
      end
   endtask

   task automatic drive_direct(input int shift);
      for (int i = 0; i < N_DIRECT; i++) begin
         set_direct(i, rand_sample(shift));
      end
   endtask

   task automatic drive_sources();
      adc.ch1 = rand_sample(0);
      adc.ch2 = rand_sample(0);
      asg.ch1 = rand_sample(0);
      asg.ch2 = rand_sample(0);
      for (int i = 0; i < N_SLOTS; i++) begin
         slot_sig[i] = rand_sample(0);
      end
   endtask

   task automatic settle_dac();
      tick(SUM_LATENCY + 1);           // longest path from input to dac_o
      dac_m = model_dac();
   endtask

   task automatic check_sinks(input string name);
      sample_pair_t e_scope, e_pwm;
      for (int k = 0; k < N_SLOTS; k++) begin
         cmp_sample(name, model_source(int'(ssel_m[k])), slot_in[k]);
      end
      e_scope.ch1 = model_source(int'(ssel_m[SINK_SCOPE1]));
      e_scope.ch2 = model_source(int'(ssel_m[SINK_SCOPE2]));
      e_pwm.ch1   = model_source(int'(ssel_m[SINK_PWM0]));
      e_pwm.ch2   = model_source(int'(ssel_m[SINK_PWM1]));
      cmp_pair(name, e_scope, scope);
      cmp_pair(name, e_pwm, pwm);
   endtask

   task automatic write_out_sel(input int i, input out_sel_e osel);
      logic [31:0] rd;
      logic        er;
      cfg_access(1'b1, REG_OUTPUT_SEL, 4'(i), 32'(osel), rd, er);
      cmp_word("output sel write err", 32'd0, 32'(er));
      dsel_m[i] = osel;
   endtask

   initial begin : main
      logic [31:0]  rd;
      logic [31:0]  r;
      logic         er;
      int           idx;
      src_sel_e     sel;
      sample_pair_t exp_q [$];

      rstn     = 1'b0;
      adc      = '0;
      asg      = '0;
      slot_sig = '0;
      slot_dir = '0;
      cfg_req  = '0;
      dac_m    = '0;
      dsel_m   = '{default: OUT_OFF};
      for (int k = 0; k < N_SINKS; k++) begin
         ssel_m[k] = SRC_ADC1;          // slots and scope 1
      end
      ssel_m[SINK_SCOPE2] = SRC_ADC2;
      ssel_m[SINK_PWM0]   = SRC_NONE;
      ssel_m[SINK_PWM1]   = SRC_NONE;
      drive_sources();
      tick(RESET_CYCLES);
      rstn = 1'b1;
      tick(1);

      // reset state and select readback
      cmp_word("reset ack err", 32'd0, 32'({cfg_rsp.ack, cfg_rsp.err}));
      cmp_pair("reset dac", '0, dac);
      check_sinks("reset routing");
      for (int k = 0; k < N_SINKS; k++) begin
         cfg_access(1'b0, REG_INPUT_SEL, 4'(k), '0, rd, er);
         cmp_word("reset input sel", 32'(ssel_m[k]), rd);
      end
      for (int k = 0; k < N_DIRECT; k++) begin
         cfg_access(1'b0, REG_OUTPUT_SEL, 4'(k), '0, rd, er);
         cmp_word("reset output sel", 32'(OUT_OFF), rd);
      end

      // routing, two slot directs held so dac feedback is nonzero
      slot_dir[0] = rand_sample(0);
      slot_dir[1] = rand_sample(0);
      write_out_sel(0, OUT_1);
      write_out_sel(1, OUT_2);
      settle_dac();
      cmp_pair("route dac", dac_m, dac);
      repeat (N_ROUTE) begin
         r   = rand_bits(4);
         idx = int'(r) % N_SINKS;
         r   = rand_bits(SEL_W);
         sel = src_sel_e'(r[SEL_W-1:0]);
         if (sel == SRC_INVALID) begin
            sel = SRC_NONE;             // dead code goes to the error test
         end
         cfg_access(1'b1, REG_INPUT_SEL, 4'(idx), 32'(sel), rd, er);
         cmp_word("route write err", 32'd0, 32'(er));
         ssel_m[idx] = sel;
         drive_sources();
         tick(1);
         check_sinks("route");
      end

      // summing with held inputs
      repeat (10) begin
         for (int i = 0; i < N_DIRECT; i++) begin
            r = rand_bits(2);
            write_out_sel(i, out_sel_e'(r[1:0]));
         end
         drive_direct(int'(rand_bits(2)));
         settle_dac();
         cmp_pair("sum held", dac_m, dac);
      end

      // streaming, one new direct set per cycle
      for (int n = 0; n < N_STREAM + SUM_LATENCY; n++) begin
         if (exp_q.size() == SUM_LATENCY) begin
            cmp_pair("sum stream", exp_q.pop_front(), dac);
         end
         drive_direct(int'(rand_bits(2)));
         exp_q.push_back(model_dac());
         tick(1);
      end

      // saturation on dac1 only, full scale with alternating sign
      for (int rnd = 0; rnd < 6; rnd++) begin
         r   = rand_bits(4);
         idx = 1 + int'(r) % N_DIRECT;  // one contributor never clips
         for (int i = 0; i < N_DIRECT; i++) begin
            write_out_sel(i, (i < idx) ? OUT_1 : OUT_OFF);
            if (rnd[0]) begin
               set_direct(i, sample_t'(SAT_LO + int'(rand_bits(6))));
            end else begin
               set_direct(i, sample_t'(SAT_HI - int'(rand_bits(6))));
            end
         end
         settle_dac();
         cmp_pair("saturation dac", dac_m, dac);
         cfg_access(1'b0, REG_STATUS, 4'd0, '0, rd, er);
         cmp_flags("saturation status", model_flags(), rd[1:0]);
      end

      // error rules, errored reads return zero
      cfg_access(1'b1, REG_INPUT_SEL, 4'd3, 32'(SRC_INVALID), rd, er);
      cmp_word("err sel 14", 32'd1, 32'(er));
      cfg_access(1'b0, REG_INPUT_SEL, 4'd3, '0, rd, er);
      cmp_word("err sel 14 readback", 32'(ssel_m[3]), rd);
      for (int k = N_SINKS; k < 16; k++) begin
         cfg_access(1'b1, REG_INPUT_SEL, 4'(k), 32'(SRC_ADC2), rd, er);
         cmp_word("err input slot", 32'd1, 32'(er));
      end
      for (int k = N_DIRECT; k < N_SINKS; k++) begin   // scope and pwm indices
         cfg_access(1'b1, REG_OUTPUT_SEL, 4'(k), 32'(OUT_BOTH), rd, er);
         cmp_word("err output slot", 32'd1, 32'(er));
         cfg_access(1'b0, REG_OUTPUT_SEL, 4'(k), '0, rd, er);
         cmp_word("err output slot read", 32'd0, rd);
      end
      cfg_access(1'b1, cfg_reg_e'(3'd5), 4'd0, 32'd1, rd, er);
      cmp_word("err unknown reg", 32'd1, 32'(er));
      cfg_access(1'b0, REG_SIGNAL, 4'(N_SOURCES), '0, rd, er);
      cmp_word("err signal slot", 32'd1, 32'(er));
      cmp_word("err signal slot read", 32'd0, rd);
      cfg_access(1'b1, REG_STATUS, 4'd0, 32'hffff_ffff, rd, er);
      cmp_word("status write ignored", 32'd0, 32'(er));

      // signal readback, generators off the tree so dac holds
      write_out_sel(N_SLOTS, OUT_OFF);
      write_out_sel(N_SLOTS + 1, OUT_OFF);
      settle_dac();
      repeat (30) begin
         drive_sources();
         r   = rand_bits(4);
         idx = int'(r) % N_SOURCES;
         cfg_access(1'b0, REG_SIGNAL, 4'(idx), '0, rd, er);
         cmp_word("signal readback", {{(32-SAMPLE_W){1'b0}}, model_source(idx)}, rd);
      end

      $display("done after %0d cycles, %0d checks, %0d errors", cycle_cnt, checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dsp_router.f */
+incdir+dv
src/dsp_pkg.sv
src/dsp_cfg_regs.sv
src/dsp_input_mux.sv
src/dsp_sum_tree.sv
src/dsp_router.sv
dv/tb_dsp_router.sv

/* Makefile */
# Verilator build and run of the dsp_router testbench

VERILATOR ?= verilator
TOP       ?= tb_dsp_router
FLIST     ?= dsp_router.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
FAIL_MSG  := ** FAIL **

SOURCES := $(wildcard src/*.sv dv/*.sv dv/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
